/* source/fhs_pkg.sv */
package fhs_pkg;

  // payload bit index, 0 to 160
  typedef logic [7:0] bit_cnt_t;

  // FHS field types
  typedef logic [33:0] parity_t;
  typedef logic [23:0] lap_t;
  typedef logic [7:0]  uap_t;
  typedef logic [15:0] nap_t;
  typedef logic [23:0] cod_t;
  typedef logic [25:0] clk27_2_t;
  typedef logic [2:0]  lt_addr_t;
  typedef logic [2:0]  psm_t;
  typedef logic [1:0]  sr_t;

  typedef logic [15:0] crc_t;

  // APB bus widths
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // payload lengths, field bits then field bits plus CRC
  localparam bit_cnt_t FHS_FIELD_BITS   = 8'd144;
  localparam bit_cnt_t FHS_PAYLOAD_BITS = 8'd160;

  // first bit index of each field, bit 59 is reserved
  localparam bit_cnt_t FHS_PARITY_POS  = 8'd0;
  localparam bit_cnt_t FHS_LAP_POS     = 8'd34;
  localparam bit_cnt_t FHS_EIR_POS     = 8'd58;
  localparam bit_cnt_t FHS_SR_POS      = 8'd60;
  localparam bit_cnt_t FHS_SP_POS      = 8'd62;
  localparam bit_cnt_t FHS_UAP_POS     = 8'd64;
  localparam bit_cnt_t FHS_NAP_POS     = 8'd72;
  localparam bit_cnt_t FHS_COD_POS     = 8'd88;
  localparam bit_cnt_t FHS_LT_ADDR_POS = 8'd112;
  localparam bit_cnt_t FHS_CLK_POS     = 8'd115;
  localparam bit_cnt_t FHS_PSM_POS     = 8'd141;

  // CRC-CCITT, x^16 + x^12 + x^5 + 1
  localparam crc_t CRC_POLY = 16'h1021;

  // APB register map
  localparam apb_addr_t REG_STATUS = 8'h00;
  localparam apb_addr_t REG_CTRL   = 8'h04;
  localparam apb_addr_t REG_LAP    = 8'h08;
  localparam apb_addr_t REG_MISC   = 8'h0C;
  localparam apb_addr_t REG_NAP    = 8'h10;
  localparam apb_addr_t REG_COD    = 8'h14;
  localparam apb_addr_t REG_CLK    = 8'h18;
  localparam apb_addr_t REG_PAR_LO = 8'h1C;
  localparam apb_addr_t REG_PAR_HI = 8'h20;
  localparam apb_addr_t REG_COUNT  = 8'h24;

endpackage

/* source/fhs_fields_if.sv */
`timescale 1ns/100ps

interface fhs_fields_if
  import fhs_pkg::*;
();

  // one-cycle pulse after the last payload bit
  logic     done;
  parity_t  parity;
  lap_t     lap;
  logic     eir;
  sr_t      sr;
  sr_t      sp;
  uap_t     uap;
  nap_t     nap;
  cod_t     cod;
  lt_addr_t lt_addr;
  clk27_2_t clk27_2;
  psm_t     psm;

  modport source (
    output done, parity, lap, eir, sr, sp, uap, nap, cod, lt_addr, clk27_2, psm
  );

  modport sink (
    input done, parity, lap, eir, sr, sp, uap, nap, cod, lt_addr, clk27_2, psm
  );

endinterface

/* source/fhs_field_extract.sv */
`timescale 1ns/100ps

module fhs_field_extract
  import fhs_pkg::*;
(
  input  logic         clk_6M,
  input  logic         rstz,
  input  logic         py_start,
  input  logic         py_bit_valid,
  input  logic         py_bit,
  input  logic         rx_fhs,
  fhs_fields_if.source fields
);

  bit_cnt_t bit_cnt;
  logic     pkt_active;
  logic     take_bit;
  logic     last_bit;

  // true when idx lies in [lo, hi)
  function automatic logic in_field(bit_cnt_t idx, bit_cnt_t lo, bit_cnt_t hi);
    return (idx >= lo) && (idx < hi);
  endfunction

  // a start pulse wins over a bit on the same edge
  assign take_bit = pkt_active && py_bit_valid && !py_start;
  assign last_bit = take_bit && (bit_cnt == FHS_PAYLOAD_BITS - 8'd1);

  // bit counter and packet-active flag
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      bit_cnt     <= '0;
      pkt_active  <= 1'b0;
      fields.done <= 1'b0;
    end
    else
    begin
      fields.done <= last_bit;
      if (py_start)
      begin
        bit_cnt    <= '0;
        pkt_active <= rx_fhs;
      end
      else if (take_bit)
      begin
        bit_cnt <= bit_cnt + 8'd1;
        if (last_bit)
          pkt_active <= 1'b0;
      end
    end
  end

  // fields arrive LSB first, so shift in at the top
  always_ff @(posedge clk_6M)
  begin
    if (take_bit)
    begin
      if (in_field(bit_cnt, FHS_PARITY_POS, FHS_LAP_POS))
        fields.parity <= {py_bit, fields.parity[33:1]};
      if (in_field(bit_cnt, FHS_LAP_POS, FHS_EIR_POS))
        fields.lap <= {py_bit, fields.lap[23:1]};
      if (bit_cnt == FHS_EIR_POS)
        fields.eir <= py_bit;
      // reserved bit sits between EIR and SR and is dropped
      if (in_field(bit_cnt, FHS_SR_POS, FHS_SP_POS))
        fields.sr <= {py_bit, fields.sr[1]};
      if (in_field(bit_cnt, FHS_SP_POS, FHS_UAP_POS))
        fields.sp <= {py_bit, fields.sp[1]};
      if (in_field(bit_cnt, FHS_UAP_POS, FHS_NAP_POS))
        fields.uap <= {py_bit, fields.uap[7:1]};
      if (in_field(bit_cnt, FHS_NAP_POS, FHS_COD_POS))
        fields.nap <= {py_bit, fields.nap[15:1]};
      if (in_field(bit_cnt, FHS_COD_POS, FHS_LT_ADDR_POS))
        fields.cod <= {py_bit, fields.cod[23:1]};
      if (in_field(bit_cnt, FHS_LT_ADDR_POS, FHS_CLK_POS))
        fields.lt_addr <= {py_bit, fields.lt_addr[2:1]};
      if (in_field(bit_cnt, FHS_CLK_POS, FHS_PSM_POS))
        fields.clk27_2 <= {py_bit, fields.clk27_2[25:1]};
      if (in_field(bit_cnt, FHS_PSM_POS, FHS_FIELD_BITS))
        fields.psm <= {py_bit, fields.psm[2:1]};
    end
  end

endmodule

/* source/py_crc16_check.sv */
`timescale 1ns/100ps

module py_crc16_check
  import fhs_pkg::*;
(
  input  logic clk_6M,
  input  logic rstz,
  input  logic py_start,
  input  logic py_bit_valid,
  input  logic py_bit,
  input  uap_t crc_init,
  output logic crc_done,
  output logic crc_ok
);

  bit_cnt_t bit_cnt;
  crc_t     crc_q;
  logic     running;
  logic     take_bit;
  logic     in_data;
  logic     last_bit;
  logic     diff;
  logic     err_q;

  assign take_bit = running && py_bit_valid && !py_start;
  assign in_data  = bit_cnt < FHS_FIELD_BITS;
  assign last_bit = take_bit && (bit_cnt == FHS_PAYLOAD_BITS - 8'd1);
  // LFSR feedback in the data part, compare result in the CRC part
  assign diff     = crc_q[15] ^ py_bit;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      bit_cnt  <= '0;
      crc_q    <= '0;
      running  <= 1'b0;
      err_q    <= 1'b0;
      crc_done <= 1'b0;
      crc_ok   <= 1'b0;
    end
    else
    begin
      crc_done <= last_bit;
      if (last_bit)
        crc_ok <= !(err_q | diff);
      if (py_start)
      begin
        bit_cnt <= '0;
        crc_q   <= {8'h00, crc_init};
        err_q   <= 1'b0;
        running <= 1'b1;
      end
      else if (take_bit)
      begin
        bit_cnt <= bit_cnt + 8'd1;
        if (in_data)
          crc_q <= {crc_q[14:0], 1'b0} ^ (diff ? CRC_POLY : 16'h0000);
        else
        begin
          // received CRC is checked from register bit 15 down
          crc_q <= {crc_q[14:0], 1'b0};
          err_q <= err_q | diff;
        end
        if (last_bit)
          running <= 1'b0;
      end
    end
  end

endmodule

/* source/fhs_result_regs.sv */
`timescale 1ns/100ps

module fhs_result_regs
  import fhs_pkg::*;
(
  input  logic       clk_6M,
  input  logic       rstz,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  apb_addr_t  paddr,
  input  apb_data_t  pwdata,
  output apb_data_t  prdata,
  output logic       pready,
  output logic       pslverr,
  fhs_fields_if.sink fields,
  input  logic       crc_done,
  input  logic       crc_ok,
  output uap_t       crc_init,
  output logic       fhs_irq
);

  logic        access;
  logic        addr_hit;
  logic        wr_en;
  logic        sts_wr;
  logic        pkt_good;
  logic        pkt_bad;
  logic        new_valid;
  logic        crc_err;
  logic        irq_en;
  parity_t     pub_parity;
  lap_t        pub_lap;
  logic        pub_eir;
  sr_t         pub_sr;
  sr_t         pub_sp;
  uap_t        pub_uap;
  nap_t        pub_nap;
  cod_t        pub_cod;
  lt_addr_t    pub_lt_addr;
  clk27_2_t    pub_clk;
  psm_t        pub_psm;
  logic [15:0] good_count;
  logic [15:0] bad_count;

  // zero wait states, transfer completes in the access phase
  assign pready  = 1'b1;
  assign access  = psel && penable;
  assign wr_en   = access && pwrite && addr_hit;
  assign sts_wr  = wr_en && (paddr == REG_STATUS);
  assign pslverr = access && !addr_hit;

  // a packet counts only when extractor and CRC finish together
  assign pkt_good = fields.done && crc_done && crc_ok;
  assign pkt_bad  = fields.done && crc_done && !crc_ok;

  // read mux and address decode
  always_comb
  begin
    addr_hit = 1'b1;
    prdata   = '0;
    case (paddr)
      REG_STATUS: prdata = {30'd0, crc_err, new_valid};
      REG_CTRL:   prdata = {23'd0, irq_en, crc_init};
      REG_LAP:    prdata = {8'd0, pub_lap};
      REG_MISC:   prdata = {9'd0, pub_psm, 1'b0, pub_lt_addr, pub_uap,
                            2'b00, pub_sp, pub_sr, 1'b0, pub_eir};
      REG_NAP:    prdata = {16'd0, pub_nap};
      REG_COD:    prdata = {8'd0, pub_cod};
      REG_CLK:    prdata = {4'd0, pub_clk, 2'b00};
      REG_PAR_LO: prdata = pub_parity[31:0];
      REG_PAR_HI: prdata = {30'd0, pub_parity[33:32]};
      REG_COUNT:  prdata = {bad_count, good_count};
      default:    addr_hit = 1'b0;
    endcase
  end

  // control, status, counters and interrupt
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      crc_init   <= '0;
      irq_en     <= 1'b0;
      new_valid  <= 1'b0;
      crc_err    <= 1'b0;
      good_count <= '0;
      bad_count  <= '0;
      fhs_irq    <= 1'b0;
    end
    else
    begin
      if (wr_en && (paddr == REG_CTRL))
      begin
        crc_init <= pwdata[7:0];
        irq_en   <= pwdata[8];
      end
      // write one to clear, a new event wins over the clear
      new_valid <= pkt_good | (new_valid & ~(sts_wr & pwdata[0]));
      crc_err   <= pkt_bad | (crc_err & ~(sts_wr & pwdata[1]));
      if (pkt_good && (good_count != 16'hFFFF))
        good_count <= good_count + 16'd1;
      if (pkt_bad && (bad_count != 16'hFFFF))
        bad_count <= bad_count + 16'd1;
      fhs_irq <= irq_en && new_valid;
    end
  end

  // published fields, only from a packet with a good CRC
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      pub_parity  <= '0;
      pub_lap     <= '0;
      pub_eir     <= 1'b0;
      pub_sr      <= '0;
      pub_sp      <= '0;
      pub_uap     <= '0;
      pub_nap     <= '0;
      pub_cod     <= '0;
      pub_lt_addr <= '0;
      pub_clk     <= '0;
      pub_psm     <= '0;
    end
    else if (pkt_good)
    begin
      pub_parity  <= fields.parity;
      pub_lap     <= fields.lap;
      pub_eir     <= fields.eir;
      pub_sr      <= fields.sr;
      pub_sp      <= fields.sp;
      pub_uap     <= fields.uap;
      pub_nap     <= fields.nap;
      pub_cod     <= fields.cod;
      pub_lt_addr <= fields.lt_addr;
      pub_clk     <= fields.clk27_2;
      pub_psm     <= fields.psm;
    end
  end

endmodule

/* source/fhs_rx_top.sv */
`timescale 1ns/100ps

module fhs_rx_top
  import fhs_pkg::*;
(
  input  logic      clk_6M,
  input  logic      rstz,
  // payload bit stream
  input  logic      py_start,
  input  logic      py_bit_valid,
  input  logic      py_bit,
  input  logic      rx_fhs,
  // APB slave
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  output logic      fhs_irq
);

  logic crc_done;
  logic crc_ok;
  uap_t crc_init;

  fhs_fields_if fields ();

  fhs_field_extract u_extract (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .py_start     (py_start),
    .py_bit_valid (py_bit_valid),
    .py_bit       (py_bit),
    .rx_fhs       (rx_fhs),
    .fields       (fields.source)
  );

  // CRC runs on every packet, FHS type only matters to the extractor
  py_crc16_check u_crc (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .py_start     (py_start),
    .py_bit_valid (py_bit_valid),
    .py_bit       (py_bit),
    .crc_init     (crc_init),
    .crc_done     (crc_done),
    .crc_ok       (crc_ok)
  );

  fhs_result_regs u_regs (
    .clk_6M   (clk_6M),
    .rstz     (rstz),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .fields   (fields.sink),
    .crc_done (crc_done),
    .crc_ok   (crc_ok),
    .crc_init (crc_init),
    .fhs_irq  (fhs_irq)
  );

endmodule

/* testbench/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk_6M,
  output logic rstz
);

  // 40 ns period
  initial
  begin
    clk_6M = 1'b0;
    forever #20 clk_6M = ~clk_6M;
  end

  // reset held for two cycles, released on a falling edge
  initial
  begin
    rstz = 1'b0;
    repeat (2) @(posedge clk_6M);
    @(negedge clk_6M);
    rstz = 1'b1;
  end

endmodule

/* testbench/fhs_rx_chk.sv */
`timescale 1ns/100ps

module fhs_rx_chk (
  input logic clk_6M,
  input logic rstz,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic fhs_irq,
  input logic irq_en,
  input logic py_start,
  input logic crc_done
);

  logic seen_start;
  int   assert_fails = 0;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      seen_start <= 1'b0;
    else if (py_start)
      seen_start <= 1'b1;
  end

  a_pready: assert property (@(posedge clk_6M) disable iff (!rstz) pready)
    else
    begin
      assert_fails++;
      $error("pready dropped low");
    end

  a_pslverr: assert property (@(posedge clk_6M) disable iff (!rstz)
    pslverr |-> (psel && penable))
    else
    begin
      assert_fails++;
      $error("pslverr outside an access phase");
    end

  // irq is registered, so irq_en must have been set one cycle earlier
  a_irq: assert property (@(posedge clk_6M) disable iff (!rstz)
    $rose(fhs_irq) |-> $past(irq_en))
    else
    begin
      assert_fails++;
      $error("fhs_irq rose without irq_en");
    end

  a_crc_done: assert property (@(posedge clk_6M) disable iff (!rstz)
    crc_done |-> seen_start)
    else
    begin
      assert_fails++;
      $error("crc_done without a preceding py_start");
    end

endmodule

bind fhs_rx_top fhs_rx_chk u_chk (
  .clk_6M   (clk_6M),
  .rstz     (rstz),
  .psel     (psel),
  .penable  (penable),
  .pready   (pready),
  .pslverr  (pslverr),
  .fhs_irq  (fhs_irq),
  .irq_en   (u_regs.irq_en),
  .py_start (py_start),
  .crc_done (crc_done)
);

/* testbench/fhs_rx_tb.sv */
`timescale 1ns/100ps

module fhs_rx_tb
  import fhs_pkg::*;
();

  logic      clk_6M;
  logic      rstz;
  logic      py_start;
  logic      py_bit_valid;
  logic      py_bit;
  logic      rx_fhs;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      fhs_irq;

  logic [31:0]  lcg_state = 32'hae9fd213;
  int           errors = 0;
  int           test_errors = 0;
  int           tests_run = 0;
  int           tests_failed = 0;
  logic [159:0] payload;
  logic [15:0]  exp_good = '0;
  logic [15:0]  exp_bad = '0;
  uap_t         cur_init = '0;
  // model of the published field registers from LAP to PAR_HI
  apb_data_t    pkt_word [7];
  apb_data_t    pub_word [7] = '{default: '0};
  apb_addr_t    field_addr [7] = '{REG_LAP, REG_MISC, REG_NAP, REG_COD,
                                   REG_CLK, REG_PAR_LO, REG_PAR_HI};
  string        field_name [7] = '{"LAP", "MISC", "NAP", "COD", "CLK",
                                   "PAR_LO", "PAR_HI"};

  tb_clkgen u_clkgen (
    .clk_6M (clk_6M),
    .rstz   (rstz)
  );

  fhs_rx_top DUT (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .py_start     (py_start),
    .py_bit_valid (py_bit_valid),
    .py_bit       (py_bit),
    .rx_fhs       (rx_fhs),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .fhs_irq      (fhs_irq)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ (lcg_state >> 15);
  endfunction

  // CRC-CCITT LFSR with the register starting at {8'h00, uap}
  function automatic crc_t crc_ccitt(logic [143:0] data, uap_t init);
    crc_t c;
    logic fb;
    c = {8'h00, init};
    for (int i = 0; i < 144; i++)
    begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0};
      if (fb)
        c = c ^ CRC_POLY;
    end
    return c;
  endfunction

  // all APB tasks start and end on a falling edge
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk_6M);
    penable = 1'b1;
    @(negedge clk_6M);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk_6M);
    penable = 1'b1;
    @(negedge clk_6M);
    data    = prdata;
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_expect(input apb_addr_t addr, input string name, input apb_data_t exp);
    apb_data_t rd;
    logic      err;
    apb_read(addr, rd, err);
    if (rd !== exp)
    begin
      $display("mismatch %s: expected %h, actual %h", name, exp, rd);
      errors++;
    end
    if (err !== 1'b0)
    begin
      $display("mismatch pslverr on %s: expected 0, actual %h", name, err);
      errors++;
    end
  endtask

  task automatic check_published();
    for (int i = 0; i < 7; i++)
      read_expect(field_addr[i], field_name[i], pub_word[i]);
    read_expect(REG_COUNT, "COUNT", {exp_bad, exp_good});
  endtask

  // random fields, payload bits and the expected register words
  task automatic make_packet(input uap_t init);
    logic [31:0]  r;
    logic [31:0]  q;
    logic [143:0] body;
    crc_t         crc;
    r = next_rand();
    q = next_rand();
    // layout from bit 0 is parity, lap, eir, reserved, sr, sp, uap, nap, cod, lt_addr, clk, psm
    body[31:0]    = next_rand();
    body[33:32]   = r[1:0];
    body[57:34]   = q[23:0];
    body[63:58]   = q[29:24];
    body[95:64]   = next_rand();
    body[127:96]  = next_rand();
    body[143:128] = r[31:16];
    crc = crc_ccitt(body, init);
    payload[143:0] = body;
    for (int k = 0; k < 16; k++)
      payload[144 + k] = crc[15 - k];
    pkt_word[0] = {8'd0, body[57:34]};
    pkt_word[1] = (apb_data_t'(body[143:141]) << 20) | (apb_data_t'(body[114:112]) << 16)
                | (apb_data_t'(body[71:64]) << 8) | (apb_data_t'(body[63:62]) << 4)
                | (apb_data_t'(body[61:60]) << 2) | apb_data_t'(body[58]);
    pkt_word[2] = {16'd0, body[87:72]};
    pkt_word[3] = {8'd0, body[111:88]};
    pkt_word[4] = apb_data_t'(body[140:115]) << 2;
    pkt_word[5] = body[31:0];
    pkt_word[6] = {30'd0, body[33:32]};
  endtask

  task automatic send_packet(input logic fhs, input int nbits);
    int gap;
    py_start = 1'b1;
    rx_fhs   = fhs;
    @(negedge clk_6M);
    py_start = 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      gap = next_rand() % 3;
      py_bit_valid = 1'b0;
      repeat (gap) @(negedge clk_6M);
      py_bit_valid = 1'b1;
      py_bit       = payload[i];
      @(negedge clk_6M);
    end
    py_bit_valid = 1'b0;
  endtask

  task automatic wait_status(input apb_data_t mask, input string what);
    apb_data_t rd;
    logic      err;
    int        polls;
    rd    = '0;
    polls = 0;
    while (((rd & mask) == 0) && (polls < 40))
    begin
      apb_read(REG_STATUS, rd, err);
      polls++;
    end
    if ((rd & mask) == 0)
    begin
      $display("timeout: %s never showed up in STATUS", what);
      errors++;
    end
  endtask

  task automatic wait_irq(input logic level);
    int cycles;
    cycles = 0;
    while ((fhs_irq !== level) && (cycles < 20))
    begin
      @(negedge clk_6M);
      cycles++;
    end
    if (fhs_irq !== level)
    begin
      $display("timeout: fhs_irq did not go to %0d", level);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_errors)
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_errors);
    end
    else
      $display("test %s: ok", name);
    test_errors = errors;
  endtask

  initial
  begin
    apb_data_t rd;
    logic      err;
    int        n;
    uap_t      new_init;
    py_start     = 1'b0;
    py_bit_valid = 1'b0;
    py_bit       = 1'b0;
    rx_fhs       = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    n = 0;
    while ((rstz !== 1'b1) && (n < 10))
    begin
      @(negedge clk_6M);
      n++;
    end
    if (rstz !== 1'b1)
    begin
      $display("reset was never released");
      errors++;
    end
    @(negedge clk_6M);

    read_expect(REG_STATUS, "STATUS", '0);
    read_expect(REG_CTRL, "CTRL", '0);
    check_published();
    if (fhs_irq !== 1'b0)
    begin
      $display("mismatch fhs_irq: expected 0, actual %h", fhs_irq);
      errors++;
    end
    finish_test("reset values");

    for (int i = 0; i < 5; i++)
    begin
      make_packet(cur_init);
      send_packet(1'b1, FHS_PAYLOAD_BITS);
      wait_status(32'h1, "new_valid");
      pub_word = pkt_word;
      exp_good++;
      read_expect(REG_STATUS, "STATUS", 32'h1);
      check_published();
      apb_write(REG_STATUS, 32'h3);
    end
    finish_test("good packets");

    // one flipped bit anywhere in fields or CRC
    for (int i = 0; i < 4; i++)
    begin
      make_packet(cur_init);
      n = next_rand() % FHS_PAYLOAD_BITS;
      payload[n] = ~payload[n];
      send_packet(1'b1, FHS_PAYLOAD_BITS);
      wait_status(32'h2, "crc_err");
      exp_bad++;
      read_expect(REG_STATUS, "STATUS", 32'h2);
      check_published();
      apb_write(REG_STATUS, 32'h3);
    end
    finish_test("corrupted packets");

    make_packet(cur_init);
    send_packet(1'b0, FHS_PAYLOAD_BITS);
    repeat (6) @(negedge clk_6M);
    read_expect(REG_STATUS, "STATUS", '0);
    check_published();
    make_packet(cur_init);
    send_packet(1'b1, 100);
    // the restart carries the remaining 60 bits so a missed restart would end a packet
    send_packet(1'b1, 60);
    repeat (6) @(negedge clk_6M);
    read_expect(REG_STATUS, "STATUS", '0);
    check_published();
    finish_test("ignored packets");

    rd = next_rand();
    new_init = cur_init ^ (rd[15:8] | 8'h01);
    apb_write(REG_CTRL, {24'd0, new_init});
    read_expect(REG_CTRL, "CTRL", {24'd0, new_init});
    make_packet(new_init);
    send_packet(1'b1, FHS_PAYLOAD_BITS);
    wait_status(32'h1, "new_valid");
    pub_word = pkt_word;
    exp_good++;
    check_published();
    apb_write(REG_STATUS, 32'h3);
    make_packet(cur_init);
    send_packet(1'b1, FHS_PAYLOAD_BITS);
    wait_status(32'h2, "crc_err");
    exp_bad++;
    check_published();
    apb_write(REG_STATUS, 32'h3);
    cur_init = new_init;
    finish_test("crc init change");

    apb_write(REG_CTRL, {23'd0, 1'b1, cur_init});
    make_packet(cur_init);
    send_packet(1'b1, FHS_PAYLOAD_BITS);
    wait_status(32'h1, "new_valid");
    pub_word = pkt_word;
    exp_good++;
    wait_irq(1'b1);
    apb_write(REG_STATUS, 32'h1);
    wait_irq(1'b0);
    apb_read(8'h40, rd, err);
    if (err !== 1'b1)
    begin
      $display("mismatch pslverr on unmapped read: expected 1, actual %h", err);
      errors++;
    end
    apb_write(8'h40, 32'hFFFF_FFFF);
    read_expect(REG_CTRL, "CTRL", {23'd0, 1'b1, cur_init});
    read_expect(REG_STATUS, "STATUS", '0);
    check_published();
    finish_test("interrupt and unmapped access");

    errors += DUT.u_chk.assert_fails;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* fhs_rx.f */
source/fhs_pkg.sv
source/fhs_fields_if.sv
source/fhs_field_extract.sv
source/py_crc16_check.sv
source/fhs_result_regs.sv
source/fhs_rx_top.sv
testbench/tb_clkgen.sv
testbench/fhs_rx_chk.sv
testbench/fhs_rx_tb.sv

/* Bender.yml */
package:
  name: fhs_rx

sources:
  - files:
      - source/fhs_pkg.sv
      - source/fhs_fields_if.sv
      - source/fhs_field_extract.sv
      - source/py_crc16_check.sv
      - source/fhs_result_regs.sv
      - source/fhs_rx_top.sv
  - target: test
    files:
      - testbench/tb_clkgen.sv
      - testbench/fhs_rx_chk.sv
      - testbench/fhs_rx_tb.sv
